// File: hw/store_defines.svh
`ifndef STORE_DEFINES_SVH
`define STORE_DEFINES_SVH

// byte address width of the core.
`define STORE_ADDR_W 32

// index bits, one 32-bit word per line.
`define STORE_INDEX_W 4

// number of lines in the direct-mapped array.
`define STORE_LINES (1 << `STORE_INDEX_W)

// queue slots the memory grants after reset.
`define STORE_MEM_CREDITS 2

// config port geometry.
`define STORE_CFG_ADDR_W 2
`define STORE_CFG_DATA_W 16

`endif

// File: hw/store_pkg.sv
`include "store_defines.svh"

`default_nettype none

package store_pkg;

    // access size of a store.
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } store_width_t;

    // one store from the execution unit.
    typedef struct packed {
        logic [`STORE_ADDR_W-1:0] address;
        logic [31:0]              data;     // already placed on its byte lanes.
        store_width_t             width;
    } store_entry_t;

    // per-line status bits.
    typedef struct packed {
        logic valid;
        logic dirty;
    } status_t;

    // selects the line fields an access touches.
    typedef struct packed {
        logic data;
        logic dirty;
        logic valid;
    } line_enable_t;

    // write-through request carried to memory.
    typedef struct packed {
        logic [`STORE_ADDR_W-1:0] address;
        logic [31:0]              data;
        store_width_t             width;
        logic [3:0]               byte_mask;
    } mem_store_req_t;

endpackage : store_pkg

`default_nettype wire

// File: hw/cache_array.sv
`include "store_defines.svh"

`default_nettype none

module cache_array (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire logic [`STORE_ADDR_W-1:0] addr_i,
    input  store_pkg::line_enable_t       read_i,
    input  store_pkg::line_enable_t       write_i,
    input  wire logic [31:0]              data_i,
    input  wire logic [3:0]               byte_i,
    input  store_pkg::status_t            status_i,
    output logic                          hit_o,
    output logic                          dirty_o,
    input  wire logic                     fill_we_i,
    input  wire logic [`STORE_ADDR_W-1:0] fill_addr_i,
    input  wire logic [31:0]              fill_data_i,
    input  wire logic [`STORE_ADDR_W-1:0] lookup_addr_i,
    output logic [31:0]                   lookup_data_o,
    output store_pkg::status_t            lookup_status_o,
    output logic                          lookup_hit_o
);

    localparam int IDX_W = `STORE_INDEX_W;
    localparam int TAG_W = `STORE_ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0]        tag_q  [`STORE_LINES];
    logic [31:0]             data_q [`STORE_LINES];
    logic [`STORE_LINES-1:0] valid_q;
    logic [`STORE_LINES-1:0] dirty_q;

    logic [IDX_W-1:0] st_idx, fill_idx, lk_idx;
    logic [TAG_W-1:0] st_tag, fill_tag, lk_tag;

    assign st_idx   = addr_i[2 +: IDX_W];        // word lines, skip byte offset.
    assign st_tag   = addr_i[`STORE_ADDR_W-1 -: TAG_W];
    assign fill_idx = fill_addr_i[2 +: IDX_W];
    assign fill_tag = fill_addr_i[`STORE_ADDR_W-1 -: TAG_W];
    assign lk_idx   = lookup_addr_i[2 +: IDX_W];
    assign lk_tag   = lookup_addr_i[`STORE_ADDR_W-1 -: TAG_W];

    // status bits, fill written last so it wins on the same index.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            hit_o   <= 1'b0;
            dirty_o <= 1'b0;
        end else begin
            if (|read_i) begin
                hit_o   <= valid_q[st_idx] && (tag_q[st_idx] == st_tag);
                dirty_o <= dirty_q[st_idx];
            end
            if (write_i.valid) valid_q[st_idx] <= status_i.valid;
            if (write_i.dirty) dirty_q[st_idx] <= status_i.dirty;
            if (fill_we_i) begin
                valid_q[fill_idx] <= 1'b1;   // refilled line is clean.
                dirty_q[fill_idx] <= 1'b0;
            end
        end
    end

    // tag and data storage.
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (write_i.data && byte_i[b]) begin
                data_q[st_idx][8*b +: 8] <= data_i[8*b +: 8];   // byte merge.
            end
        end
        if (fill_we_i) begin
            data_q[fill_idx] <= fill_data_i;
            tag_q[fill_idx]  <= fill_tag;
        end
    end

    assign lookup_data_o         = data_q[lk_idx];
    assign lookup_status_o.valid = valid_q[lk_idx];
    assign lookup_status_o.dirty = dirty_q[lk_idx];
    assign lookup_hit_o          = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

endmodule : cache_array

`default_nettype wire

// File: hw/store_controller.sv
`include "store_defines.svh"

`default_nettype none

module store_controller (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire logic                     halt_i,
    input  wire logic                     stall_i,

    input  wire logic                     request_i,
    input  store_pkg::store_entry_t       entry_i,
    output logic                          valid_o,

    input  wire logic                     cache_hit_i,
    input  wire logic                     cache_dirty_i,
    output logic [`STORE_ADDR_W-1:0]      cache_addr_o,
    output logic [31:0]                   cache_data_o,
    output logic [3:0]                    cache_byte_o,
    output store_pkg::status_t            cache_status_o,
    output store_pkg::line_enable_t       cache_read_o,
    output store_pkg::line_enable_t       cache_write_o,

    output logic                          mem_issue_o,
    output store_pkg::mem_store_req_t     mem_req_o,
    input  wire logic                     mem_done_i,

    output logic                          hit_o,
    output logic                          miss_o
);

    typedef enum logic [1:0] {IDLE, OUTCOME, WRITE_THROUGH, WAIT} state_t;

    state_t                  state_q, state_d;
    store_pkg::store_entry_t entry_q;
    logic [3:0]              byte_mask;
    logic                    go;

    assign go = !halt_i && !stall_i;

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && request_i) entry_q <= entry_i;   // accept.
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) state_q <= IDLE;
        else          state_q <= state_d;
    end

    // lanes touched, from size and low address bits.
    always_comb begin
        case (entry_q.width)
            store_pkg::BYTE:      byte_mask = 4'b0001 << entry_q.address[1:0];
            store_pkg::HALF_WORD: byte_mask = 4'b0011 << {entry_q.address[1], 1'b0};
            default:              byte_mask = 4'b1111;
        endcase
    end

    always_comb begin
        state_d        = state_q;
        valid_o        = 1'b0;
        cache_read_o   = '0;
        cache_write_o  = '0;
        cache_status_o = '0;
        mem_issue_o    = 1'b0;
        hit_o          = 1'b0;
        miss_o         = 1'b0;

        case (state_q)
            IDLE: begin
                if (request_i) begin
                    cache_read_o = '1;   // outcome next cycle.
                    state_d      = OUTCOME;
                end
            end

            OUTCOME: begin
                if (cache_hit_i) begin
                    if (go) begin
                        cache_write_o  = '1;   // data, dirty and valid.
                        cache_status_o = '1;
                        valid_o        = 1'b1;
                        hit_o          = 1'b1;
                        state_d        = IDLE;
                    end
                end else if (go) begin
                    mem_issue_o = 1'b1;
                    miss_o      = 1'b1;
                    state_d     = WRITE_THROUGH;
                    // a clean line may hold stale bytes of this word
                    if (!cache_dirty_i) begin
                        cache_write_o.valid  = 1'b1;
                        cache_status_o.valid = 1'b0;
                    end
                end
            end

            WRITE_THROUGH: begin
                if (mem_done_i) begin
                    if (go) begin
                        valid_o = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = WAIT;   // ack seen, hold completion.
                    end
                end
            end

            WAIT: begin
                if (go) begin
                    valid_o = 1'b1;
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    assign cache_addr_o = (state_q == IDLE) ? entry_i.address : entry_q.address;
    assign cache_data_o = entry_q.data;
    assign cache_byte_o = byte_mask;

    assign mem_req_o.address   = entry_q.address;
    assign mem_req_o.data      = entry_q.data;
    assign mem_req_o.width     = entry_q.width;
    assign mem_req_o.byte_mask = byte_mask;

endmodule : store_controller

`default_nettype wire

// File: hw/store_credit_port.sv
`include "store_defines.svh"

`default_nettype none

module store_credit_port (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 issue_i,
    input  store_pkg::mem_store_req_t req_i,
    output logic                      mem_req_valid_o,
    output store_pkg::mem_store_req_t mem_req_o,
    input  wire logic                 mem_credit_i,
    input  wire logic                 mem_ack_i,
    output logic                      done_o
);

    localparam int CRED_W = $clog2(`STORE_MEM_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`STORE_MEM_CREDITS);

    logic                      pend_q;
    store_pkg::mem_store_req_t req_q;
    logic [CRED_W-1:0]         credit_q;
    logic                      send;

    assign send = pend_q && (credit_q != '0);   // one credit per request.

    always_ff @(posedge clk_i) begin
        if (issue_i) req_q <= req_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q   <= 1'b0;
            credit_q <= CRED_MAX;
        end else begin
            if (issue_i)   pend_q <= 1'b1;
            else if (send) pend_q <= 1'b0;
            case ({send, mem_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   if (credit_q != CRED_MAX) credit_q <= credit_q + 1'b1;   // saturate.
                default: credit_q <= credit_q;   // none, or spent and returned.
            endcase
        end
    end

    assign mem_req_valid_o = send;
    assign mem_req_o       = req_q;
    assign done_o          = mem_ack_i;   // oldest request completed.

endmodule : store_credit_port

`default_nettype wire

// File: hw/store_ctrl_regs.sv
`include "store_defines.svh"

`default_nettype none

module store_ctrl_regs (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        cfg_we_i,
    input  wire logic [`STORE_CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [`STORE_CFG_DATA_W-1:0] cfg_wdata_i,
    output logic [`STORE_CFG_DATA_W-1:0]      cfg_rdata_o,
    output logic                             halt_o,
    input  wire logic                        hit_i,
    input  wire logic                        miss_i
);

    logic [`STORE_CFG_DATA_W-1:0] hit_cnt_q, miss_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halt_o      <= 1'b0;
            hit_cnt_q   <= '0;
            miss_cnt_q  <= '0;
            cfg_rdata_o <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == 2'd0) halt_o <= cfg_wdata_i[0];
            if (hit_i)  hit_cnt_q  <= hit_cnt_q + 1'b1;    // wraps.
            if (miss_i) miss_cnt_q <= miss_cnt_q + 1'b1;
            case (cfg_addr_i)
                2'd0:    cfg_rdata_o <= {{(`STORE_CFG_DATA_W-1){1'b0}}, halt_o};
                2'd1:    cfg_rdata_o <= hit_cnt_q;
                2'd2:    cfg_rdata_o <= miss_cnt_q;
                default: cfg_rdata_o <= '0;
            endcase
        end
    end

endmodule : store_ctrl_regs

`default_nettype wire

// File: hw/store_subsystem_top.sv
`include "store_defines.svh"

`default_nettype none

module store_subsystem_top (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         store_req_i,
    input  store_pkg::store_entry_t           store_entry_i,
    input  wire logic                         stall_i,
    output logic                              store_valid_o,
    output logic                              mem_req_valid_o,
    output store_pkg::mem_store_req_t         mem_req_o,
    input  wire logic                         mem_credit_i,
    input  wire logic                         mem_ack_i,
    input  wire logic                         fill_we_i,
    input  wire logic [`STORE_ADDR_W-1:0]     fill_addr_i,
    input  wire logic [31:0]                  fill_data_i,
    input  wire logic [`STORE_ADDR_W-1:0]     lookup_addr_i,
    output logic [31:0]                       lookup_data_o,
    output store_pkg::status_t                lookup_status_o,
    output logic                              lookup_hit_o,
    input  wire logic                         cfg_we_i,
    input  wire logic [`STORE_CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [`STORE_CFG_DATA_W-1:0] cfg_wdata_i,
    output logic [`STORE_CFG_DATA_W-1:0]      cfg_rdata_o
);

    logic                      halt, hit_pulse, miss_pulse;
    logic                      cache_hit, cache_dirty, mem_issue, mem_done;
    logic [`STORE_ADDR_W-1:0]  cache_addr;
    logic [31:0]               cache_data;
    logic [3:0]                cache_byte;
    store_pkg::status_t        cache_status;
    store_pkg::line_enable_t   cache_read, cache_write;
    store_pkg::mem_store_req_t issue_req;

    store_controller u_ctrl (
        .clk_i, .rst_n_i, .halt_i(halt), .stall_i,
        .request_i(store_req_i), .entry_i(store_entry_i), .valid_o(store_valid_o),
        .cache_hit_i(cache_hit), .cache_dirty_i(cache_dirty),
        .cache_addr_o(cache_addr), .cache_data_o(cache_data), .cache_byte_o(cache_byte),
        .cache_status_o(cache_status), .cache_read_o(cache_read),
        .cache_write_o(cache_write), .mem_issue_o(mem_issue), .mem_req_o(issue_req),
        .mem_done_i(mem_done), .hit_o(hit_pulse), .miss_o(miss_pulse)
    );

    cache_array u_array (
        .clk_i, .rst_n_i, .addr_i(cache_addr), .read_i(cache_read),
        .write_i(cache_write), .data_i(cache_data), .byte_i(cache_byte),
        .status_i(cache_status), .hit_o(cache_hit), .dirty_o(cache_dirty),
        .fill_we_i, .fill_addr_i, .fill_data_i,
        .lookup_addr_i, .lookup_data_o, .lookup_status_o, .lookup_hit_o
    );

    store_credit_port u_credit (
        .clk_i, .rst_n_i, .issue_i(mem_issue), .req_i(issue_req),
        .mem_req_valid_o, .mem_req_o, .mem_credit_i, .mem_ack_i, .done_o(mem_done)
    );

    store_ctrl_regs u_regs (
        .clk_i, .rst_n_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
        .halt_o(halt), .hit_i(hit_pulse), .miss_i(miss_pulse)
    );

endmodule : store_subsystem_top

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;   // 20 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: verification/tb_mem_model.sv
`include "store_defines.svh"

`default_nettype none

module tb_mem_model #(
    parameter int MAX_DELAY = 8
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      req_valid_i,
    input  wire store_pkg::mem_store_req_t req_i,
    input  wire logic                      hold_credits_i,
    output logic                           credit_o,
    output logic                           ack_o,
    output int                             req_count_o,
    output int                             ack_count_o,
    output int                             credits_o,
    output int                             in_flight_o,
    output store_pkg::mem_store_req_t      last_req_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int delay_left;
    int owed;
    int returned;

    assign credits_o   = `STORE_MEM_CREDITS - req_count_o + returned;
    assign in_flight_o = req_count_o - returned;

    initial begin
        credit_o    = 1'b0;
        ack_o       = 1'b0;
        req_count_o = 0;
        ack_count_o = 0;
        delay_left  = 0;
        owed        = 0;
        returned    = 0;
        last_req_o  = '0;
    end

    // one falling edge per count, the last one carries the ack.
    always @(posedge clk_i) begin
        if (rst_n_i && req_valid_i) begin
            req_count_o <= req_count_o + 1;
            last_req_o  <= req_i;
            delay_left  <= 1 + int'($urandom % MAX_DELAY);
            $display("mem: store addr %h data %h mask %b", req_i.address, req_i.data,
                     req_i.byte_mask);
        end else if (delay_left > 0) begin
            delay_left <= delay_left - 1;
        end
    end

    // acks and credit returns change on the falling edge.
    always @(negedge clk_i) begin
        ack_o    <= 1'b0;
        credit_o <= 1'b0;
        if (!hold_credits_i && owed > 0) begin
            credit_o <= 1'b1;
            owed     <= owed - 1;
            returned <= returned + 1;
        end
        if (delay_left == 1) begin
            ack_o       <= 1'b1;
            ack_count_o <= ack_count_o + 1;
            owed        <= owed + ((!hold_credits_i && owed > 0) ? 0 : 1);
        end
    end

endmodule : tb_mem_model

`default_nettype wire

// File: verification/tb_store_subsystem.sv
`include "store_defines.svh"

`default_nettype none

module tb_store_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED        = 71;
    localparam int NUM_STORES  = 24;
    localparam int MEM_DELAY   = 8;
    localparam int STORE_LIMIT = 100;
    localparam int TIMEOUT_NS  = (NUM_STORES + 16) * (MEM_DELAY + 40) * 20;

    logic clk, rst_n;
    logic store_req, stall, store_valid;
    store_pkg::store_entry_t   store_entry;
    logic mem_req_valid, mem_credit, mem_ack;
    store_pkg::mem_store_req_t mem_req, last_req;
    logic fill_we;
    logic [31:0] fill_addr, fill_data, lookup_addr, lookup_data;
    store_pkg::status_t lookup_status;
    logic lookup_hit, cfg_we, hold_credits, halt_m;
    logic [`STORE_CFG_ADDR_W-1:0] cfg_addr;
    logic [`STORE_CFG_DATA_W-1:0] cfg_wdata, cfg_rdata;
    int req_count, ack_count, mdl_credits, in_flight;

    // reference cache contents.
    logic [25:0] ref_tag   [16];
    logic [31:0] ref_data  [16];
    logic [15:0] ref_valid;
    logic [15:0] ref_dirty;
    int ref_hits, ref_misses, errors, checks;

    tb_clock_gen clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    tb_mem_model #(.MAX_DELAY(MEM_DELAY)) mem (
        .clk_i(clk), .rst_n_i(rst_n), .req_valid_i(mem_req_valid), .req_i(mem_req),
        .hold_credits_i(hold_credits), .credit_o(mem_credit), .ack_o(mem_ack),
        .req_count_o(req_count), .ack_count_o(ack_count), .credits_o(mdl_credits),
        .in_flight_o(in_flight), .last_req_o(last_req)
    );

    store_subsystem_top uut (
        .clk_i(clk), .rst_n_i(rst_n), .store_req_i(store_req), .store_entry_i(store_entry),
        .stall_i(stall), .store_valid_o(store_valid), .mem_req_valid_o(mem_req_valid),
        .mem_req_o(mem_req), .mem_credit_i(mem_credit), .mem_ack_i(mem_ack),
        .fill_we_i(fill_we), .fill_addr_i(fill_addr), .fill_data_i(fill_data),
        .lookup_addr_i(lookup_addr), .lookup_data_o(lookup_data),
        .lookup_status_o(lookup_status), .lookup_hit_o(lookup_hit),
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
        .cfg_rdata_o(cfg_rdata)
    );

    always @(posedge clk) begin
        if (!rst_n) halt_m <= 1'b0;
        else if (cfg_we && cfg_addr == 2'd0) halt_m <= cfg_wdata[0];
    end

    credit_avail: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> mdl_credits > 0)
        else begin
            errors++;
            $display("memory request sent while the memory had no credit left");
        end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= `STORE_MEM_CREDITS)
        else begin
            errors++;
            $display("more requests in flight than memory credits");
        end

    hold_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (halt_m || stall) |-> !store_valid)
        else begin
            errors++;
            $display("store completed while halted or stalled");
        end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run hung", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [3:0] lane_mask(input store_pkg::store_width_t w,
                                             input logic [1:0] off);
        case (w)
            store_pkg::BYTE:      return 4'b0001 << off;
            store_pkg::HALF_WORD: return off[1] ? 4'b1100 : 4'b0011;
            default:              return 4'b1111;
        endcase
    endfunction

    function automatic logic [1:0] pick_offset(input store_pkg::store_width_t w);
        logic [1:0] r;
        r = 2'($urandom % 4);
        case (w)
            store_pkg::BYTE:      return r;
            store_pkg::HALF_WORD: return {r[1], 1'b0};
            default:              return 2'b00;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual)
            else begin
                errors++;
                $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            end
    endtask

    task automatic fill_line(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        fill_we   = 1'b1;
        fill_addr = addr;
        fill_data = data;
        @(negedge clk);
        fill_we = 1'b0;
        ref_tag[addr[5:2]]   = addr[31:6];
        ref_data[addr[5:2]]  = data;
        ref_valid[addr[5:2]] = 1'b1;
        ref_dirty[addr[5:2]] = 1'b0;
    endtask

    task automatic cfg_write_halt(input logic value);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = 2'd0;
        cfg_wdata = {15'd0, value};
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read_check(input string name, input logic [1:0] addr,
                                  input logic [15:0] expected);
        @(negedge clk);
        cfg_addr = addr;
        @(negedge clk);
        check_value(name, 32'(expected), 32'(cfg_rdata));
    endtask

    task automatic check_line(input string name, input logic [31:0] addr);
        logic [3:0] idx;
        idx = addr[5:2];
        @(negedge clk);
        lookup_addr = addr;
        @(negedge clk);
        check_value({name, " valid"}, 32'(ref_valid[idx]), 32'(lookup_status.valid));
        if (ref_valid[idx]) begin
            check_value({name, " dirty"}, 32'(ref_dirty[idx]), 32'(lookup_status.dirty));
            check_value({name, " data"}, ref_data[idx], lookup_data);
            check_value({name, " tag hit"}, 32'(ref_tag[idx] == addr[31:6]),
                        32'(lookup_hit));
        end
    endtask

    // release_at > 0 means halt or stall is held until that cycle.
    task automatic run_store(input string name, input logic [31:0] addr,
                             input logic [31:0] data, input store_pkg::store_width_t width,
                             input int release_at);
        logic [3:0] idx;
        logic       hit;
        logic [3:0] mask;
        logic       seen;
        int         lat;
        int         req_before;
        int         ack_before;
        idx        = addr[5:2];
        hit        = ref_valid[idx] && (ref_tag[idx] == addr[31:6]);
        mask       = lane_mask(width, addr[1:0]);
        req_before = req_count;
        ack_before = ack_count;
        seen       = 1'b0;
        lat        = 0;
        @(negedge clk);
        store_req           = 1'b1;
        store_entry.address = addr;
        store_entry.data    = data;
        store_entry.width   = width;
        @(posedge clk);
        while (!seen && lat < STORE_LIMIT) begin
            @(posedge clk);
            lat++;
            seen = store_valid;   // value of the cycle just ended.
            @(negedge clk);
            if (!seen && release_at > 0 && lat <= release_at) begin
                check_value({name, " no request while held"}, 32'(req_before),
                            32'(req_count));
                if (lat == release_at) begin
                    stall     = 1'b0;
                    cfg_we    = 1'b1;
                    cfg_addr  = 2'd0;
                    cfg_wdata = '0;
                end
            end else begin
                cfg_we = 1'b0;
            end
        end
        store_req = 1'b0;
        cfg_we    = 1'b0;
        if (!seen) begin
            errors++;
            $display("store %s never completed", name);
        end else if (hit) begin
            if (release_at == 0) check_value({name, " latency"}, 32'd1, 32'(lat));
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) ref_data[idx][8*b +: 8] = data[8*b +: 8];
            end
            ref_dirty[idx] = 1'b1;
            ref_valid[idx] = 1'b1;
            ref_hits++;
        end else begin
            check_value({name, " request count"}, 32'(req_before + 1), 32'(req_count));
            check_value({name, " ack count"}, 32'(ack_before + 1), 32'(ack_count));
            check_value({name, " mem address"}, addr, last_req.address);
            check_value({name, " mem data"}, data, last_req.data);
            check_value({name, " mem width"}, 32'(width), 32'(last_req.width));
            check_value({name, " mem mask"}, 32'(mask), 32'(last_req.byte_mask));
            if (!ref_dirty[idx]) ref_valid[idx] = 1'b0;   // clean line dropped.
            ref_misses++;
        end
        check_line(name, addr);
    endtask

    function automatic logic [31:0] make_addr(input logic [25:0] tag, input logic [3:0] idx,
                                              input logic [1:0] off);
        return {tag, idx, off};
    endfunction

    initial begin
        store_pkg::store_width_t w;
        logic [31:0] a;
        void'($urandom(SEED));
        store_req = 1'b0;
        store_entry = '0;
        stall = 1'b0;
        fill_we = 1'b0;
        fill_addr = '0;
        fill_data = '0;
        lookup_addr = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        hold_credits = 1'b0;
        ref_valid = '0;
        ref_dirty = '0;
        ref_hits = 0;
        ref_misses = 0;
        errors = 0;
        checks = 0;
        wait (rst_n);

        // hit with byte merge
        w = store_pkg::store_width_t'($urandom % 3);
        a = make_addr(26'd5, 4'd3, pick_offset(w));
        fill_line(a, $urandom);
        run_store("hit_store", a, $urandom, w, 0);

        // miss on a dirty line, then on a clean one
        run_store("miss_dirty", make_addr(26'd9, 4'd3, 2'd0), $urandom, store_pkg::WORD, 0);
        fill_line(make_addr(26'd2, 4'd7, 2'd0), $urandom);
        run_store("miss_clean", make_addr(26'd4, 4'd7, 2'd2), $urandom,
                  store_pkg::HALF_WORD, 0);

        // credits withheld, third miss waits in the port
        hold_credits = 1'b1;
        run_store("credit_a", make_addr(26'd11, 4'd1, 2'd1), $urandom, store_pkg::BYTE, 0);
        run_store("credit_b", make_addr(26'd12, 4'd2, 2'd0), $urandom, store_pkg::WORD, 0);
        fork
            run_store("credit_c", make_addr(26'd13, 4'd4, 2'd0), $urandom,
                      store_pkg::WORD, 0);
            begin
                repeat (30) @(posedge clk);
                hold_credits = 1'b0;
            end
        join

        // halt on a hit, stall on a miss
        fill_line(make_addr(26'd6, 4'd9, 2'd0), $urandom);
        cfg_write_halt(1'b1);
        run_store("halt_hit", make_addr(26'd6, 4'd9, 2'd0), $urandom, store_pkg::WORD, 5);
        @(negedge clk);
        stall = 1'b1;
        run_store("stall_miss", make_addr(26'd8, 4'd10, 2'd0), $urandom, store_pkg::WORD, 4);

        // random mix for the counters
        for (int i = 0; i < NUM_STORES; i++) begin
            w = store_pkg::store_width_t'($urandom % 3);
            a = make_addr(26'($urandom % 3), 4'($urandom % 4), pick_offset(w));
            if ($urandom % 3 == 0) fill_line({a[31:2], 2'b00}, $urandom);
            run_store("random_store", a, $urandom, w, 0);
        end
        cfg_read_check("hit_count", 2'd1, 16'(ref_hits));
        cfg_read_check("miss_count", 2'd2, 16'(ref_misses));

        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_store_subsystem

`default_nettype wire

// File: list.f
+incdir+hw
hw/store_pkg.sv
hw/cache_array.sv
hw/store_controller.sv
hw/store_credit_port.sv
hw/store_ctrl_regs.sv
hw/store_subsystem_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_store_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the store subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module tb_store_subsystem \
    -o sim_store_subsystem

./obj_dir/sim_store_subsystem > run.log 2>&1 || true
cat run.log

if grep -q "Simulation completed successfully" run.log; then
    echo "run.sh: PASS"
else
    echo "run.sh: FAIL"
    exit 1
fi
